// File: project.f
+incdir+hdl
hdl/isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_credit_if.sv
hdl/fetch_unit.sv
hdl/inst_queue.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/exec_unit.sv
hdl/core_top.sv
sim/tb_core.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        -f project.f --top-module tb_core -Mdir "$BUILD_DIR" -o tb_core; then
    echo "run: verilator build returned an error"
    exit 1
fi

"./$BUILD_DIR/tb_core" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "run: simulation returned status $status"
    exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
    exit 1
fi

exit 0

// File: sim/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module tb_core;
    import isa_pkg::*;

    localparam int          PROG_MAX      = 32;
    localparam int          WB_TIMEOUT    = 64;
    localparam int          REQ_TIMEOUT   = 64;
    localparam int          RESET_TIMEOUT = 64;
    localparam logic [15:0] LFSR_SEED     = 16'd59294;

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] FUNC_SLL    = 6'h00;
    localparam logic [5:0] FUNC_ADDU   = 6'h21;
    localparam logic [5:0] FUNC_SUBU   = 6'h23;
    localparam logic [5:0] FUNC_AND    = 6'h24;
    localparam logic [5:0] FUNC_OR     = 6'h25;
    localparam logic [5:0] FUNC_XOR    = 6'h26;
    localparam logic [5:0] FUNC_SLT    = 6'h2a;

    logic       aclk;
    logic       aresetn;
    logic       inst_req;
    word_t      inst_addr;
    word_t      inst_rdata;
    logic       inst_addr_ok;
    logic       inst_data_ok;
    word_t      debug_wb_pc;
    logic [3:0] debug_wb_rf_wen;
    reg_idx_t   debug_wb_rf_wnum;
    word_t      debug_wb_rf_wdata;

    // program table: instruction, expected write register, expected write data
    word_t       prog_inst [PROG_MAX];
    reg_idx_t    prog_wnum [PROG_MAX];
    word_t       prog_wdata [PROG_MAX];
    int          prog_len;
    logic [15:0] lfsr_state;
    int          mismatch_count;
    int          fault_count;

    core_top dut0 (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .inst_req          (inst_req),
        .inst_addr         (inst_addr),
        .inst_rdata        (inst_rdata),
        .inst_addr_ok      (inst_addr_ok),
        .inst_data_ok      (inst_data_ok),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        aclk = 1'b0;
        forever #50 aclk = ~aclk;
    end

    function automatic word_t encode_rtype(input logic [5:0] funct, input int rs, input int rt,
                                           input int rd, input int sa);
        return {OPC_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'(sa), funct};
    endfunction

    function automatic word_t encode_itype(input logic [5:0] opcode, input int rs, input int rt,
                                           input logic [15:0] imm);
        return {opcode, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic add_row(input word_t inst, input int wnum, input word_t wdata);
        prog_inst[prog_len]  = inst;
        prog_wnum[prog_len]  = reg_idx_t'(wnum);
        prog_wdata[prog_len] = wdata;
        prog_len++;
    endtask

    task automatic load_program();
        // ori reads the lui result in the very next cycle
        add_row(encode_itype(OPC_LUI, 0, 1, 16'h1234), 1, 32'h1234_0000);
        add_row(encode_itype(OPC_ORI, 1, 1, 16'h5678), 1, 32'h1234_5678);
        add_row(encode_itype(OPC_ADDIU, 0, 2, 16'hffff), 2, 32'hffff_ffff);
        add_row(encode_itype(OPC_ORI, 0, 3, 16'h8000), 3, 32'h0000_8000);
        add_row(encode_itype(OPC_ADDIU, 3, 4, 16'h7fff), 4, 32'h0000_ffff);
        add_row(encode_rtype(FUNC_ADDU, 1, 2, 5, 0), 5, 32'h1234_5677);
        add_row(encode_rtype(FUNC_SUBU, 3, 1, 6, 0), 6, 32'hedcc_2988);
        add_row(encode_rtype(FUNC_AND, 1, 4, 7, 0), 7, 32'h0000_5678);
        add_row(encode_rtype(FUNC_OR, 1, 3, 8, 0), 8, 32'h1234_d678);
        add_row(encode_rtype(FUNC_XOR, 1, 2, 9, 0), 9, 32'hedcb_a987);
        // signed compares, -1 against 0 both ways
        add_row(encode_rtype(FUNC_SLT, 2, 0, 10, 0), 10, 32'h0000_0001);
        add_row(encode_rtype(FUNC_SLT, 0, 2, 11, 0), 11, 32'h0000_0000);
        add_row(encode_rtype(FUNC_SLT, 6, 1, 12, 0), 12, 32'h0000_0001);
        add_row(encode_rtype(FUNC_SLL, 0, 1, 13, 4), 13, 32'h2345_6780);
        // $0 write shows up in the record but is dropped
        add_row(encode_itype(OPC_ADDIU, 1, 0, 16'h0001), 0, 32'h1234_5679);
        add_row(encode_rtype(FUNC_ADDU, 0, 1, 14, 0), 14, 32'h1234_5678);
        add_row(encode_rtype(FUNC_OR, 0, 0, 15, 0), 15, 32'h0000_0000);
        add_row(encode_itype(OPC_ADDIU, 2, 2, 16'h0002), 2, 32'h0000_0001);
        add_row(encode_rtype(FUNC_SLL, 0, 2, 16, 31), 16, 32'h8000_0000);
        add_row(encode_rtype(FUNC_SUBU, 16, 2, 17, 0), 17, 32'h7fff_ffff);
    endtask

    // taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = (value << 1) | int'(lfsr_state[0]);
        end
    endtask

    // past the table the memory reads as zero
    function automatic word_t fetch_word(input word_t addr);
        word_t offset;
        int    idx;
        offset = addr - `RESET_PC;
        idx = int'(offset >> 2);
        if (idx < prog_len) begin
            return prog_inst[idx];
        end
        return '0;
    endfunction

    task automatic check_word(input string name, input int entry, input word_t got,
                              input word_t expected);
        if (got !== expected) begin
            $display("MISMATCH %s at entry %0d: got %h, expected %h", name, entry, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_reg(input string name, input int entry, input reg_idx_t got,
                             input reg_idx_t expected);
        if (got !== expected) begin
            $display("MISMATCH %s at entry %0d: got %h, expected %h", name, entry, got, expected);
            mismatch_count++;
        end
    endtask

    task automatic check_strobe(input string name, input int entry, input logic [3:0] got,
                                input logic [3:0] expected);
        if (got !== expected) begin
            $display("MISMATCH %s at entry %0d: got %h, expected %h", name, entry, got, expected);
            mismatch_count++;
        end
    endtask

    // one request at a time, random accept and return delays
    initial begin : memory_model
        int    waited;
        int    addr_delay;
        int    data_delay;
        int    req_count;
        word_t req_addr;
        logic  running;
        running = 1'b1;
        waited = 0;
        req_count = 0;
        while (aresetn !== 1'b1 && running) begin
            @(negedge aclk);
            waited++;
            if (aresetn === 1'b0 && inst_req !== 1'b0) begin
                $display("instruction request raised while reset is asserted");
                fault_count++;
            end
            if (waited > RESET_TIMEOUT) begin
                $display("memory model gave up waiting for reset release");
                fault_count++;
                running = 1'b0;
            end
        end
        while (running) begin
            waited = 0;
            @(negedge aclk);
            while (!inst_req && running) begin
                waited++;
                if (waited > REQ_TIMEOUT) begin
                    $display("memory model saw no instruction request for %0d cycles",
                             REQ_TIMEOUT);
                    fault_count++;
                    running = 1'b0;
                end else begin
                    @(negedge aclk);
                end
            end
            if (running) begin
                req_addr = inst_addr;
                // requests walk the program one word at a time
                check_word("inst_addr", req_count, inst_addr,
                           `RESET_PC + word_t'(4 * req_count));
                req_count++;
                draw_bits(2, addr_delay);
                draw_bits(2, data_delay);
                data_delay = data_delay + 1;
                repeat (addr_delay) @(posedge aclk);
                @(posedge aclk);
                inst_addr_ok <= 1'b1;
                @(posedge aclk);
                inst_addr_ok <= 1'b0;
                repeat (data_delay - 1) @(posedge aclk);
                inst_data_ok <= 1'b1;
                inst_rdata   <= fetch_word(req_addr);
                @(posedge aclk);
                inst_data_ok <= 1'b0;
                inst_rdata   <= '0;
            end
        end
    end

    initial begin : main_sequence
        int    waited;
        int    idx;
        logic  ok;
        word_t exp_pc;
        aresetn        <= 1'b0;
        inst_rdata     <= '0;
        inst_addr_ok   <= 1'b0;
        inst_data_ok   <= 1'b0;
        mismatch_count = 0;
        fault_count    = 0;
        lfsr_state     = LFSR_SEED;
        prog_len       = 0;
        load_program();
        repeat (10) @(posedge aclk);
        aresetn <= 1'b1;
        ok = 1'b1;
        idx = 0;
        // one entry more than the table, the zero word retires as sll $0
        while (ok && idx <= prog_len) begin
            waited = 0;
            @(negedge aclk);
            while (debug_wb_rf_wen === 4'h0 && ok) begin
                waited++;
                if (waited > WB_TIMEOUT) begin
                    $display("no writeback for entry %0d within %0d cycles", idx, WB_TIMEOUT);
                    fault_count++;
                    ok = 1'b0;
                end else begin
                    @(negedge aclk);
                end
            end
            if (ok) begin
                exp_pc = `RESET_PC + word_t'(4 * idx);
                check_strobe("debug_wb_rf_wen", idx, debug_wb_rf_wen, 4'hf);
                check_word("debug_wb_pc", idx, debug_wb_pc, exp_pc);
                if (idx < prog_len) begin
                    check_reg("debug_wb_rf_wnum", idx, debug_wb_rf_wnum, prog_wnum[idx]);
                    check_word("debug_wb_rf_wdata", idx, debug_wb_rf_wdata, prog_wdata[idx]);
                end else begin
                    check_reg("debug_wb_rf_wnum", idx, debug_wb_rf_wnum, '0);
                    check_word("debug_wb_rf_wdata", idx, debug_wb_rf_wdata, '0);
                end
                idx++;
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, fault_count);
        if (mismatch_count == 0 && fault_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/core_top.sv
`timescale 1ns/10ps
`default_nettype none

module core_top (
    input  wire                    aclk,
    input  wire                    aresetn,

    output wire                    inst_req,
    output wire isa_pkg::word_t    inst_addr,
    input  wire isa_pkg::word_t    inst_rdata,
    input  wire                    inst_addr_ok,
    input  wire                    inst_data_ok,

    output wire isa_pkg::word_t    debug_wb_pc,
    output wire [3:0]              debug_wb_rf_wen,
    output wire isa_pkg::reg_idx_t debug_wb_rf_wnum,
    output wire isa_pkg::word_t    debug_wb_rf_wdata
);

    // fetch to queue to execute
    fetch_credit_if q_if ();

    fetch_unit fetch0 (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .inst_addr_ok (inst_addr_ok),
        .inst_data_ok (inst_data_ok),
        .inst_rdata   (inst_rdata),
        .inst_req     (inst_req),
        .inst_addr    (inst_addr),
        .q            (q_if.producer)
    );

    inst_queue queue0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .q       (q_if.buffer)
    );

    exec_unit exec0 (
        .aclk              (aclk),
        .aresetn           (aresetn),
        .q                 (q_if.consumer),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module exec_unit (
    input  wire                aclk,
    input  wire                aresetn,
    fetch_credit_if.consumer   q,
    output isa_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_rf_wen,
    output isa_pkg::reg_idx_t  debug_wb_rf_wnum,
    output isa_pkg::word_t     debug_wb_rf_wdata
);
    import isa_pkg::*;
    import core_pkg::*;

    fetch_pkt_t   head;
    inst_fields_t f;
    imm_t         imm;
    word_t        imm_ext;
    alu_op_t      op;
    logic         use_imm;
    logic         imm_sign;
    logic         dst_rt;
    logic         dec_wen;
    logic         rf_wen;
    reg_idx_t     wreg;
    word_t        rs_data;
    word_t        rt_data;
    word_t        alu_b;
    word_t        result;

    // no hazards here, so every queued instruction retires at once
    assign q.pop = q.not_empty;

    assign head = q.head;
    assign f    = inst_fields_t'(head.inst);
    assign imm  = head.inst[15:0];

    always_comb begin
        op       = ALU_NOP;
        use_imm  = 1'b0;
        imm_sign = 1'b0;
        dst_rt   = 1'b0;
        dec_wen  = 1'b0;
        case (f.opcode)
            OP_SPECIAL: begin
                dec_wen = 1'b1;
                case (f.funct)
                    FN_ADDU: op = ALU_ADD;
                    FN_SUBU: op = ALU_SUB;
                    FN_AND:  op = ALU_AND;
                    FN_OR:   op = ALU_OR;
                    FN_XOR:  op = ALU_XOR;
                    FN_SLT:  op = ALU_SLT;
                    FN_SLL:  op = ALU_SLL;
                    default: dec_wen = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                op       = ALU_ADD;
                use_imm  = 1'b1;
                imm_sign = 1'b1;
                dst_rt   = 1'b1;
                dec_wen  = 1'b1;
            end
            OP_ORI, OP_LUI: begin
                op      = (f.opcode == OP_ORI) ? ALU_OR : ALU_LUI;
                use_imm = 1'b1;
                dst_rt  = 1'b1;
                dec_wen = 1'b1;
            end
            default: begin
                op = ALU_NOP;
            end
        endcase
    end

    assign imm_ext = {{(`XLEN-16){imm_sign & imm[15]}}, imm};
    assign alu_b   = use_imm ? imm_ext : rt_data;
    assign wreg    = dst_rt ? f.rt : f.rd;
    assign rf_wen  = q.pop && dec_wen;

    reg_file rf0 (
        .aclk    (aclk),
        .aresetn (aresetn),
        .rs      (f.rs),
        .rt      (f.rt),
        .wreg    (wreg),
        .wen     (rf_wen),
        .wdata   (result),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    alu alu0 (
        .op     (op),
        .a      (rs_data),
        .b      (alu_b),
        .sa     (f.sa),
        .result (result)
    );

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            debug_wb_rf_wen <= '0;
        end else begin
            debug_wb_rf_wen <= {4{rf_wen}};
        end
    end

    always_ff @(posedge aclk) begin
        if (q.pop) begin
            debug_wb_pc       <= head.pc;
            debug_wb_rf_wnum  <= wreg;
            debug_wb_rf_wdata <= result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/alu.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module alu (
    input  wire isa_pkg::alu_op_t op,
    input  wire isa_pkg::word_t   a,
    input  wire isa_pkg::word_t   b,
    input  wire isa_pkg::shamt_t  sa,
    output isa_pkg::word_t        result
);
    import isa_pkg::*;

    logic lt;

    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = word_t'(lt);
            end
            ALU_SLL: begin
                result = b << sa;
            end
            // immediate into the upper half
            ALU_LUI: begin
                result = {b[`XLEN/2-1:0], {(`XLEN/2){1'b0}}};
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module reg_file (
    input  wire                    aclk,
    input  wire                    aresetn,
    input  wire isa_pkg::reg_idx_t rs,
    input  wire isa_pkg::reg_idx_t rt,
    input  wire isa_pkg::reg_idx_t wreg,
    input  wire                    wen,
    input  wire isa_pkg::word_t    wdata,
    output isa_pkg::word_t         rs_data,
    output isa_pkg::word_t         rt_data
);
    import isa_pkg::*;

    word_t regs [`REG_COUNT];

    // $0 is never written, so it keeps its reset value of zero
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wreg != '0)) begin
            regs[wreg] <= wdata;
        end
    end

    assign rs_data = regs[rs];
    assign rt_data = regs[rt];

endmodule

`default_nettype wire

// File: hdl/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module inst_queue (
    input  wire            aclk,
    input  wire            aresetn,
    fetch_credit_if.buffer q
);
    import core_pkg::*;

    fetch_pkt_t mem [`QUEUE_DEPTH];
    qptr_t      wr_ptr;
    qptr_t      rd_ptr;
    credit_t    count;
    logic       do_pop;

    function automatic qptr_t next_ptr(input qptr_t p);
        if (p == qptr_t'(`QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return p + qptr_t'(1);
    endfunction

    assign q.not_empty = (count != '0);
    assign q.head      = mem[rd_ptr];
    assign do_pop      = q.pop && q.not_empty;

    // freed slot goes straight back to fetch
    assign q.credit = do_pop;

    always_ff @(posedge aclk) begin
        if (q.push) begin
            mem[wr_ptr] <= q.pkt;
        end
    end

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (q.push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({q.push, do_pop})
                2'b10:   count <= count + credit_t'(1);
                2'b01:   count <= count - credit_t'(1);
                default: count <= count;
            endcase
        end
    end

    no_overflow: assert property (@(posedge aclk) disable iff (!aresetn)
        q.push |-> count != credit_t'(`QUEUE_DEPTH));

    no_underflow: assert property (@(posedge aclk) disable iff (!aresetn)
        q.pop |-> count != '0);

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "core_settings.svh"

module fetch_unit (
    input  wire                 aclk,
    input  wire                 aresetn,
    input  wire                 inst_addr_ok,
    input  wire                 inst_data_ok,
    input  wire isa_pkg::word_t inst_rdata,
    output logic                inst_req,
    output isa_pkg::word_t      inst_addr,
    fetch_credit_if.producer    q
);
    import isa_pkg::*;
    import core_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t  state;
    word_t   pc;
    word_t   req_pc;
    credit_t credits;
    logic    accept;

    // only ask while a queue slot is reserved for the answer
    assign inst_req  = aresetn && (state == ST_IDLE) && (credits != '0);
    assign inst_addr = pc;
    assign accept    = inst_req && inst_addr_ok;

    assign q.push = (state == ST_BUSY) && inst_data_ok;
    assign q.pkt  = '{pc: req_pc, inst: inst_rdata};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            state <= ST_IDLE;
            pc    <= `RESET_PC;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (inst_data_ok) begin
                        state <= ST_IDLE;
                        pc    <= pc + word_t'(4);
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            req_pc <= pc;
        end
    end

    // spend on acceptance, regain on each freed entry
    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credits <= credit_t'(`QUEUE_DEPTH);
        end else begin
            case ({q.credit, accept})
                2'b10:   credits <= credits + credit_t'(1);
                2'b01:   credits <= credits - credit_t'(1);
                default: credits <= credits;
            endcase
        end
    end

    credit_bound: assert property (@(posedge aclk) disable iff (!aresetn)
        credits <= credit_t'(`QUEUE_DEPTH));

    // memory answers only the one accepted request
    data_after_accept: assert property (@(posedge aclk) disable iff (!aresetn)
        inst_data_ok |-> state == ST_BUSY);

endmodule

`default_nettype wire

// File: hdl/fetch_credit_if.sv
`timescale 1ns/10ps
`default_nettype none

interface fetch_credit_if;
    import core_pkg::*;

    logic       push;
    fetch_pkt_t pkt;
    logic       credit;
    logic       pop;
    fetch_pkt_t head;
    logic       not_empty;

    modport producer (output push, output pkt, input credit);

    modport buffer (
        input  push,
        input  pkt,
        input  pop,
        output credit,
        output head,
        output not_empty
    );

    modport consumer (input head, input not_empty, output pop);

endinterface

`default_nettype wire

// File: hdl/core_pkg.sv
`default_nettype none

`include "core_settings.svh"

package core_pkg;

    // one fetched instruction and its address
    typedef struct packed {
        isa_pkg::word_t pc;
        isa_pkg::word_t inst;
    } fetch_pkt_t;

    // holds 0 to QUEUE_DEPTH inclusive
    typedef logic [$clog2(`QUEUE_DEPTH + 1) - 1:0] credit_t;

    typedef logic [((`QUEUE_DEPTH > 1) ? $clog2(`QUEUE_DEPTH) : 1) - 1:0] qptr_t;

endpackage

`default_nettype wire

// File: hdl/isa_pkg.sv
`default_nettype none

`include "core_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [4:0]       reg_idx_t;
    typedef logic [4:0]       shamt_t;
    typedef logic [15:0]      imm_t;

    // major opcode, bits 31:26
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    // function field of SPECIAL
    typedef enum logic [5:0] {
        FN_SLL  = 6'h00,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_SLT  = 6'h2a
    } funct_t;

    // r-type view, the low half doubles as the immediate
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;
        shamt_t   sa;
        funct_t   funct;
    } inst_fields_t;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_LUI
    } alu_op_t;

endpackage

`default_nettype wire

// File: hdl/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// machine word and address width
`define XLEN 32

`define REG_COUNT 32

// queue entries, also the number of credits fetch starts with
`define QUEUE_DEPTH 4

`define RESET_PC 32'hbfc0_0000

`endif
